//--- hdl/board_pkg.sv
// board package: clock and line rates, uart byte type, jtag instruction codes
package board_pkg;

	typedef logic [7:0] uart_byte_t; // one uart payload

	localparam int CLK_HZ        = 12_000_000;
	localparam int BAUD          = 1_000_000;
	localparam int BAUD_DIV      = CLK_HZ / BAUD;   // clk cycles per bit
	localparam int RESET_STRETCH = 8;               // rst_sys tail after rst falls
	localparam int LED_HOLD      = 256;             // led hold after last tck edge
	localparam logic LED_ACTIVE  = 1'b0;            // led is active low on the board

	// counter widths derived from the above
	localparam int RST_CNT_W  = $clog2(RESET_STRETCH + 1);
	localparam int LED_CNT_W  = $clog2(LED_HOLD + 1);
	localparam int BAUD_CNT_W = $clog2(BAUD_DIV);

	localparam int IR_W = 4;
	localparam logic [IR_W-1:0] IR_IDCODE  = 4'd1;
	localparam logic [IR_W-1:0] IR_UART_DR = 4'd2;
	localparam logic [IR_W-1:0] IR_BYPASS  = 4'd15;

	localparam logic [31:0] IDCODE = 32'h1b5e_a001; // lsb must be 1 per 1149.1

	// uart data register
	// update: [8] write request, [7:0] byte
	// capture: [9] tx_full, [8] rx_valid, [7:0] rx byte
	localparam int UART_DR_W = 10;

endpackage

//--- hdl/cdc_word.sv
// word crossing: moves one held payload between clock domains by toggle handshake
module cdc_word #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     src_clk,
	input  logic     src_rst,
	input  logic     src_valid,
	input  payload_t src_data,
	output logic     src_busy,
	input  logic     dst_clk,
	input  logic     dst_rst,
	input  logic     dst_ready,
	output logic     dst_valid,
	output payload_t dst_data
);

	payload_t   data_q;   // stable while busy, read from dst side
	logic       req_tgl;  // src domain
	logic [1:0] ack_sync; // ack back into src
	logic [1:0] req_sync; // req into dst
	logic       ack_tgl;  // dst domain
	logic       pending;

	always_ff @(posedge src_clk) begin
		if (src_valid)
			data_q <= src_data;
		if (src_rst) begin
			req_tgl  <= 1'b0;
			ack_sync <= 2'b00;
		end else begin
			ack_sync <= {ack_sync[0], ack_tgl};
			if (src_valid)
				req_tgl <= ~req_tgl; // one flip per word
		end
	end

	assign src_busy = req_tgl ^ ack_sync[1]; // until ack returns

	always_ff @(posedge dst_clk) begin
		if (dst_rst) begin
			req_sync <= 2'b00;
			ack_tgl  <= 1'b0;
		end else begin
			req_sync <= {req_sync[0], req_tgl};
			if (dst_valid)
				ack_tgl <= ~ack_tgl; // closes the request, also the ack
		end
	end

	assign pending   = req_sync[1] ^ ack_tgl;
	assign dst_valid = pending & dst_ready; // single cycle, ack clears pending
	assign dst_data  = data_q;

	a_no_launch_busy: assert property (@(posedge src_clk) disable iff (src_rst)
		src_valid |-> !src_busy)
		else $error("word launched into a busy crossing");

endmodule

//--- hdl/fpga_reset.sv
// reset generator: stretches the board reset pulse into a clean system reset
module fpga_reset (
	input  logic clk,
	input  logic rst,
	output logic rst_sys
);
	import board_pkg::*;

	logic [RST_CNT_W-1:0] stretch_cnt; // remaining tail cycles

	always_ff @(posedge clk) begin
		if (rst)
			stretch_cnt <= RST_CNT_W'(RESET_STRETCH); // reload while held
		else if (stretch_cnt != '0)
			stretch_cnt <= stretch_cnt - 1'b1;
	end

	// high during rst and for the tail after it
	assign rst_sys = rst | (stretch_cnt != '0);

	// no gap between rst falling and the counted tail
	a_rst_covers_tail: assert property (@(posedge clk) rst |=> rst_sys)
		else $error("rst_sys dropped straight after rst");

endmodule

//--- hdl/reset_sync.sv
// reset synchroniser: async assert, sync release of a reset into another domain
module reset_sync (
	input  logic clk,
	input  logic rst_in,
	output logic rst_out
);

	logic [1:0] rst_pipe; // two stages for release metastability

	// tck can be stopped while the system is in reset, so assertion
	// must not wait for an edge
	always_ff @(posedge clk or posedge rst_in) begin
		if (rst_in)
			rst_pipe <= 2'b11;
		else
			rst_pipe <= {rst_pipe[0], 1'b0}; // shift zeros in on release
	end

	assign rst_out = rst_pipe[1];

endmodule

//--- hdl/jtag_tap.sv
// jtag tap: 1149.1 controller with instruction, idcode and bypass registers
module jtag_tap (
	input  logic tck,
	input  logic trst,
	input  logic tms,
	input  logic tdi,
	output logic tdo,
	output logic uart_sel,
	output logic dr_capture,
	output logic dr_shift,
	output logic dr_update,
	input  logic uart_tdo
);
	import board_pkg::*;

	typedef enum logic [3:0] {
		S_RESET, S_IDLE,
		S_SEL_DR, S_CAP_DR, S_SHIFT_DR, S_EXIT1_DR, S_PAUSE_DR, S_EXIT2_DR, S_UPD_DR,
		S_SEL_IR, S_CAP_IR, S_SHIFT_IR, S_EXIT1_IR, S_PAUSE_IR, S_EXIT2_IR, S_UPD_IR
	} tap_state_t;

	tap_state_t state, state_nxt;
	logic [IR_W-1:0] ir;       // active instruction
	logic [IR_W-1:0] ir_shift; // ir scan chain
	logic [31:0]     id_sr;
	logic            bypass_q;
	logic            dr_tdo;   // serial out of the selected dr

	always_comb begin
		case (state)
			S_RESET:    state_nxt = tms ? S_RESET    : S_IDLE;
			S_IDLE:     state_nxt = tms ? S_SEL_DR   : S_IDLE;
			S_SEL_DR:   state_nxt = tms ? S_SEL_IR   : S_CAP_DR;
			S_CAP_DR:   state_nxt = tms ? S_EXIT1_DR : S_SHIFT_DR;
			S_SHIFT_DR: state_nxt = tms ? S_EXIT1_DR : S_SHIFT_DR;
			S_EXIT1_DR: state_nxt = tms ? S_UPD_DR   : S_PAUSE_DR;
			S_PAUSE_DR: state_nxt = tms ? S_EXIT2_DR : S_PAUSE_DR;
			S_EXIT2_DR: state_nxt = tms ? S_UPD_DR   : S_SHIFT_DR;
			S_UPD_DR:   state_nxt = tms ? S_SEL_DR   : S_IDLE;
			S_SEL_IR:   state_nxt = tms ? S_RESET    : S_CAP_IR;
			S_CAP_IR:   state_nxt = tms ? S_EXIT1_IR : S_SHIFT_IR;
			S_SHIFT_IR: state_nxt = tms ? S_EXIT1_IR : S_SHIFT_IR;
			S_EXIT1_IR: state_nxt = tms ? S_UPD_IR   : S_PAUSE_IR;
			S_PAUSE_IR: state_nxt = tms ? S_EXIT2_IR : S_PAUSE_IR;
			S_EXIT2_IR: state_nxt = tms ? S_UPD_IR   : S_SHIFT_IR;
			default:    state_nxt = tms ? S_SEL_DR   : S_IDLE; // S_UPD_IR
		endcase
	end

	always_ff @(posedge tck) begin
		if (trst) begin
			state <= S_RESET;
			ir    <= IR_IDCODE;
		end else begin
			state <= state_nxt;
			if (state == S_RESET)
				ir <= IR_IDCODE;
			else if (state == S_UPD_IR)
				ir <= ir_shift;
		end
	end

	// strobes are raw state decodes, the dr owner qualifies them
	assign dr_capture = (state == S_CAP_DR);
	assign dr_shift   = (state == S_SHIFT_DR);
	assign dr_update  = (state == S_UPD_DR);
	assign uart_sel   = (ir == IR_UART_DR);

	// scan chains, no reset needed
	always_ff @(posedge tck) begin
		if (state == S_CAP_IR)
			ir_shift <= {{(IR_W - 2){1'b0}}, 2'b01}; // fixed 01 capture pattern
		else if (state == S_SHIFT_IR)
			ir_shift <= {tdi, ir_shift[IR_W-1:1]};
		if (dr_capture) begin
			id_sr    <= IDCODE;
			bypass_q <= 1'b0;
		end else if (dr_shift) begin
			id_sr    <= {tdi, id_sr[31:1]};
			bypass_q <= tdi;                         // one bit delay
		end
	end

	always_comb begin
		case (ir)
			IR_IDCODE:  dr_tdo = id_sr[0];
			IR_UART_DR: dr_tdo = uart_tdo;
			default:    dr_tdo = bypass_q; // bypass and all unassigned codes
		endcase
	end

	// tdo moves on the falling edge, zero outside the shift states
	always_ff @(negedge tck) begin
		if (trst)
			tdo <= 1'b0;
		else if (state == S_SHIFT_IR)
			tdo <= ir_shift[0];
		else if (state == S_SHIFT_DR)
			tdo <= dr_tdo;
		else
			tdo <= 1'b0;
	end

	a_one_dr_strobe: assert property (@(posedge tck) disable iff (trst)
		$onehot0({dr_capture, dr_shift, dr_update}))
		else $error("more than one dr strobe active");

endmodule

//--- hdl/jtag_uart_bridge.sv
// jtag uart bridge: uart data register on tck with byte crossings to the clk domain
module jtag_uart_bridge (
	input  logic                  tck,
	input  logic                  trst,
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  uart_sel,
	input  logic                  dr_capture,
	input  logic                  dr_shift,
	input  logic                  dr_update,
	input  logic                  tdi,
	output logic                  uart_tdo,
	output logic                  tx_valid,
	output board_pkg::uart_byte_t tx_byte,
	input  logic                  tx_ready,
	input  logic                  rx_strobe,
	input  board_pkg::uart_byte_t rx_byte
);
	import board_pkg::*;

	logic [UART_DR_W-1:0] dr_sr;   // uart data register chain
	uart_byte_t           rx_data; // last byte handed over from clk side
	logic                 rx_valid;
	logic                 tx_full;  // tx crossing still owns a byte
	logic                 tx_launch;
	logic                 rx_busy;
	logic                 rx_hit;   // byte arriving on tck side
	uart_byte_t           rx_new;
	logic                 cap, shift, upd;

	assign cap   = dr_capture & uart_sel;
	assign shift = dr_shift & uart_sel;
	assign upd   = dr_update & uart_sel;

	// write bit set and crossing free, otherwise the write is ignored
	assign tx_launch = upd & dr_sr[8] & ~tx_full;
	assign uart_tdo  = dr_sr[0];

	always_ff @(posedge tck) begin
		if (cap)
			dr_sr <= {tx_full, rx_valid, rx_data};
		else if (shift)
			dr_sr <= {tdi, dr_sr[UART_DR_W-1:1]};
		if (rx_hit && (!rx_valid || cap))
			rx_data <= rx_new;
	end

	// rx_valid clears on read, a new byte is dropped while one is unread
	always_ff @(posedge tck) begin
		if (trst)
			rx_valid <= 1'b0;
		else if (rx_hit && (!rx_valid || cap))
			rx_valid <= 1'b1;
		else if (cap)
			rx_valid <= 1'b0;
	end

	cdc_word #(.payload_t(uart_byte_t)) tx_cdc (
		.src_clk   (tck),
		.src_rst   (trst),
		.src_valid (tx_launch),
		.src_data  (dr_sr[7:0]),
		.src_busy  (tx_full),
		.dst_clk   (clk),
		.dst_rst   (rst),
		.dst_ready (tx_ready),   // held here until the transmitter is free
		.dst_valid (tx_valid),
		.dst_data  (tx_byte)
	);

	cdc_word #(.payload_t(uart_byte_t)) rx_cdc (
		.src_clk   (clk),
		.src_rst   (rst),
		.src_valid (rx_strobe & ~rx_busy), // drop while a byte is in flight
		.src_data  (rx_byte),
		.src_busy  (rx_busy),
		.dst_clk   (tck),
		.dst_rst   (trst),
		.dst_ready (1'b1),
		.dst_valid (rx_hit),
		.dst_data  (rx_new)
	);

endmodule

//--- hdl/uart_rx.sv
// uart receiver: 8N1 with mid-bit sampling and start-bit glitch reject
module uart_rx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  rxd,
	output logic                  rx_strobe,
	output board_pkg::uart_byte_t rx_byte
);
	import board_pkg::*;

	logic [1:0]            rxd_sync; // async pin guard
	logic                  busy;
	logic [3:0]            bit_idx;  // 0 start, 1..8 data, 9 stop
	logic [BAUD_CNT_W-1:0] baud_cnt;
	uart_byte_t            shreg;    // lsb first

	always_ff @(posedge clk) begin
		if (rst) begin
			rxd_sync  <= 2'b11; // line idles high
			busy      <= 1'b0;
			bit_idx   <= '0;
			baud_cnt  <= '0;
			rx_strobe <= 1'b0;
		end else begin
			rxd_sync  <= {rxd_sync[0], rxd};
			rx_strobe <= 1'b0;
			if (!busy) begin
				if (!rxd_sync[1]) begin // low level, maybe a start bit
					busy     <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= BAUD_CNT_W'(BAUD_DIV / 2 - 1); // half a bit
				end
			end else if (baud_cnt != '0) begin
				baud_cnt <= baud_cnt - 1'b1;
			end else begin
				baud_cnt <= BAUD_CNT_W'(BAUD_DIV - 1);
				bit_idx  <= bit_idx + 1'b1;
				if (bit_idx == 4'd0) begin
					if (rxd_sync[1])
						busy <= 1'b0; // high again at mid start, glitch
				end else if (bit_idx == 4'd9) begin
					busy      <= 1'b0;
					rx_strobe <= rxd_sync[1]; // stop bit 0 drops the frame
					if (rxd_sync[1])
						rx_byte <= shreg;
				end else begin
					shreg <= {rxd_sync[1], shreg[7:1]};
				end
			end
		end
	end

endmodule

//--- hdl/uart_tx.sv
// uart transmitter: 8N1 serialiser with a ready level back to the source
module uart_tx (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  tx_valid,
	input  board_pkg::uart_byte_t tx_byte,
	output logic                  tx_ready,
	output logic                  txd
);
	import board_pkg::*;

	logic [9:0]            shreg;    // stop, data, start
	logic [3:0]            bits_left;
	logic [BAUD_CNT_W-1:0] baud_cnt;

	always_ff @(posedge clk) begin
		if (rst) begin
			shreg     <= '1; // all ones keeps the line idle
			bits_left <= '0;
			baud_cnt  <= '0;
		end else if (tx_valid && tx_ready) begin
			shreg     <= {1'b1, tx_byte, 1'b0};
			bits_left <= 4'd10;
			baud_cnt  <= BAUD_CNT_W'(BAUD_DIV - 1);
		end else if (bits_left != '0) begin
			if (baud_cnt == '0) begin
				baud_cnt  <= BAUD_CNT_W'(BAUD_DIV - 1);
				bits_left <= bits_left - 1'b1;
				shreg     <= {1'b1, shreg[9:1]}; // next bit, ones behind
			end else begin
				baud_cnt <= baud_cnt - 1'b1;
			end
		end
	end

	assign txd      = shreg[0];          // straight from a flop
	assign tx_ready = (bits_left == '0); // back high at end of stop bit

	// accepted byte starts its start bit next cycle and drops ready
	a_start_after_accept: assert property (@(posedge clk) disable iff (rst)
		(tx_valid && tx_ready) |=> (!txd && !tx_ready))
		else $error("no start bit after a byte was accepted");

endmodule

//--- hdl/activity_led.sv
// activity led: turns edges on a slow input into a visible led pulse
module activity_led (
	input  logic clk,
	input  logic rst,
	input  logic sense,
	output logic led
);
	import board_pkg::*;

	logic [2:0]           sense_q;  // 2 sync stages + history
	logic                 sense_edge;
	logic [LED_CNT_W-1:0] hold_cnt;

	always_ff @(posedge clk) begin
		sense_q <= {sense_q[1:0], sense};
		if (rst)
			hold_cnt <= '0;
		else if (sense_edge)
			hold_cnt <= LED_CNT_W'(LED_HOLD); // either edge restarts the hold
		else if (hold_cnt != '0)
			hold_cnt <= hold_cnt - 1'b1;
	end

	assign sense_edge = sense_q[2] ^ sense_q[1];
	assign led = (hold_cnt != '0) ? LED_ACTIVE : ~LED_ACTIVE;

endmodule

//--- hdl/fpga_icebreaker.sv
// icebreaker top: reset, tck conditioning, activity led around a jtag uart bridge
module fpga_icebreaker (
	input  logic clk_osc,
	input  logic rst,     // power-on pulse from the board

	input  logic tck,
	input  logic tms,
	input  logic tdi,
	output logic tdo,

	output logic led,

	output logic mirror_tck,
	output logic mirror_tms,
	output logic mirror_tdi,
	output logic mirror_tdo,

	output logic uart_tx,
	input  logic uart_rx
);
	import board_pkg::*;

	logic       clk;
	logic       rst_sys;
	logic       trst;     // tck side reset
	logic       uart_sel;
	logic       dr_capture, dr_shift, dr_update;
	logic       uart_tdo;
	logic       tx_valid, tx_ready;
	uart_byte_t tx_byte;
	logic       rx_strobe;
	uart_byte_t rx_byte;

	assign clk = clk_osc; // no pll, oscillator runs the system

	// jtag pins copied to the debug header
	assign mirror_tck = tck;
	assign mirror_tms = tms;
	assign mirror_tdi = tdi;
	assign mirror_tdo = tdo;

	fpga_reset rstgen_u (.clk(clk), .rst(rst), .rst_sys(rst_sys));

	reset_sync trst_sync_u (.clk(tck), .rst_in(rst_sys), .rst_out(trst));

	activity_led tck_led_u (.clk(clk), .rst(rst_sys), .sense(tck), .led(led));

	jtag_tap tap_u (
		.tck        (tck),
		.trst       (trst),
		.tms        (tms),
		.tdi        (tdi),
		.tdo        (tdo),
		.uart_sel   (uart_sel),
		.dr_capture (dr_capture),
		.dr_shift   (dr_shift),
		.dr_update  (dr_update),
		.uart_tdo   (uart_tdo)
	);

	jtag_uart_bridge bridge_u (
		.tck        (tck),
		.trst       (trst),
		.clk        (clk),
		.rst        (rst_sys),
		.uart_sel   (uart_sel),
		.dr_capture (dr_capture),
		.dr_shift   (dr_shift),
		.dr_update  (dr_update),
		.tdi        (tdi),
		.uart_tdo   (uart_tdo),
		.tx_valid   (tx_valid),
		.tx_byte    (tx_byte),
		.tx_ready   (tx_ready),
		.rx_strobe  (rx_strobe),
		.rx_byte    (rx_byte)
	);

	uart_tx uart_tx_u (
		.clk      (clk),
		.rst      (rst_sys),
		.tx_valid (tx_valid),
		.tx_byte  (tx_byte),
		.tx_ready (tx_ready),
		.txd      (uart_tx)
	);

	uart_rx uart_rx_u (
		.clk       (clk),
		.rst       (rst_sys),
		.rxd       (uart_rx),
		.rx_strobe (rx_strobe),
		.rx_byte   (rx_byte)
	);

endmodule

//--- tests/tb_jtag_tasks.svh
// board pin drivers: bit-banged tap access, uart frame send and uart frame capture
`ifndef TB_JTAG_TASKS_SVH
`define TB_JTAG_TASKS_SVH

// one tck period, 4 clk_osc cycles, tdo read just before the rising edge
task automatic jtag_clock(input logic tms_v, input logic tdi_v, output logic tdo_v);
	@(posedge clk_osc);
	#1;
	tck = 1'b0; // tap moves tdo on this edge
	tms = tms_v;
	tdi = tdi_v;
	repeat (2) @(posedge clk_osc);
	tdo_v = tdo; // settled since the falling edge
	#1;
	tck = 1'b1;
	@(posedge clk_osc);
endtask

task automatic idle_clocks(input int n);
	logic b;
	for (int i = 0; i < n; i++)
		jtag_clock(1'b0, 1'b0, b); // stays in run-test/idle
endtask

// five or more tms high reach test-logic-reset from anywhere
task automatic jtag_reset();
	logic b;
	repeat (6) jtag_clock(1'b1, 1'b0, b); // also clocks trst out
	jtag_clock(1'b0, 1'b0, b);
endtask

task automatic scan_ir(input logic [IR_W-1:0] code);
	logic b;
	jtag_clock(1'b1, 1'b0, b); // select-dr
	jtag_clock(1'b1, 1'b0, b); // select-ir
	jtag_clock(1'b0, 1'b0, b); // capture-ir
	jtag_clock(1'b0, 1'b0, b); // into shift-ir
	for (int i = 0; i < IR_W; i++)
		jtag_clock(i == IR_W - 1, code[i], b); // lsb first, last bit exits
	jtag_clock(1'b1, 1'b0, b); // update-ir
	jtag_clock(1'b0, 1'b0, b); // back to idle
endtask

// len bits in lsb first, dout holds what came out on tdo
task automatic scan_dr(input logic [31:0] din, input int len, output logic [31:0] dout);
	logic b;
	dout = '0;
	jtag_clock(1'b1, 1'b0, b); // select-dr
	jtag_clock(1'b0, 1'b0, b); // capture-dr
	jtag_clock(1'b0, 1'b0, b); // into shift-dr
	for (int i = 0; i < len; i++) begin
		jtag_clock(i == len - 1, din[i], b);
		dout[i] = b;
	end
	jtag_clock(1'b1, 1'b0, b); // update-dr
	jtag_clock(1'b0, 1'b0, b);
endtask

// 8N1, each bit held BAUD_DIV clk cycles
task automatic send_uart_byte(input uart_byte_t b);
	logic [9:0] line_bits;
	line_bits = {1'b1, b, 1'b0};
	for (int i = 0; i < 10; i++) begin
		@(posedge clk_osc);
		#1;
		uart_rx = line_bits[i];
		repeat (BAUD_DIV - 1) @(posedge clk_osc);
	end
endtask

// finds the start edge, then samples every bit at its middle
task automatic capture_frame(output logic [9:0] bits, output logic ok, input int limit);
	int waited;
	bits = '1;
	ok = 1'b0;
	waited = 0;
	do begin
		@(negedge clk_osc);
		waited++;
	end while (uart_tx !== 1'b0 && waited < limit);
	if (uart_tx === 1'b0) begin
		ok = 1'b1;
		repeat (BAUD_DIV / 2) @(negedge clk_osc); // middle of the start bit
		for (int i = 0; i < 10; i++) begin
			bits[i] = uart_tx;
			if (i < 9)
				repeat (BAUD_DIV) @(negedge clk_osc);
		end
	end
endtask

`endif

//--- tests/tb_fpga_icebreaker.sv
// board testbench: idcode, bypass and uart bridge traffic through the icebreaker top
module tb_fpga_icebreaker;
	timeunit 1ns;
	timeprecision 100ps;
	import board_pkg::*;

	localparam int TX_POLLS   = 20;   // tx_full scans before giving up
	localparam int FRAME_WAIT = 1000; // clk cycles allowed to the start bit
	localparam int N_BYTES    = 4;

	logic clk_osc;
	logic rst;
	logic tck, tms, tdi, tdo;
	logic led;
	logic mirror_tck, mirror_tms, mirror_tdi, mirror_tdo;
	logic uart_tx, uart_rx;

	int err_count;
	int err_at_start; // errors before the running test
	int test_count;
	int failed_count;

	fpga_icebreaker fpga_icebreaker_inst (
		.clk_osc    (clk_osc),
		.rst        (rst),
		.tck        (tck),
		.tms        (tms),
		.tdi        (tdi),
		.tdo        (tdo),
		.led        (led),
		.mirror_tck (mirror_tck),
		.mirror_tms (mirror_tms),
		.mirror_tdi (mirror_tdi),
		.mirror_tdo (mirror_tdo),
		.uart_tx    (uart_tx),
		.uart_rx    (uart_rx)
	);

	always #2 clk_osc = ~clk_osc; // 4 ns

	`include "tb_jtag_tasks.svh"

	// line order: start, data lsb first, stop
	function automatic logic [9:0] frame_bits(input uart_byte_t b);
		logic [9:0] f;
		f[0] = 1'b0;
		for (int i = 0; i < 8; i++)
			f[i + 1] = b[i];
		f[9] = 1'b1;
		return f;
	endfunction

	// uart_dr as loaded on capture
	function automatic logic [UART_DR_W-1:0] capture_word(input logic tx_full,
			input logic rx_valid, input uart_byte_t b);
		return {tx_full, rx_valid, b};
	endfunction

	task automatic check_value(input string sig, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", sig, got, exp);
			err_count++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("error: %s", msg);
		err_count++;
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (err_count == err_at_start) begin
			$display("%s: ok", name);
		end else begin
			failed_count++;
			$display("%s: FAILED with %0d errors", name, err_count - err_at_start);
		end
		err_at_start = err_count;
	endtask

	// reads uart_dr without the write bit until the tx crossing is free
	task automatic wait_tx_free();
		logic [31:0] word;
		int polls;
		polls = 0;
		do begin
			scan_dr(32'h0, UART_DR_W, word);
			polls++;
		end while (word[9] !== 1'b0 && polls < TX_POLLS);
		if (word[9] !== 1'b0)
			report_error("tx crossing stayed full, byte not written");
	endtask

	// debug header follows the jtag pins all the time
	always @(negedge clk_osc) begin
		check_value("mirror pins", 32'({mirror_tck, mirror_tms, mirror_tdi, mirror_tdo}),
			32'({tck, tms, tdi, tdo}));
	end

	initial begin
		logic [31:0] din, dout;
		logic [9:0]  frame;
		logic        frame_ok;
		uart_byte_t  b;
		int          waited;

		void'($urandom(32'h3631ced3));
		clk_osc = 1'b0;
		rst = 1'b1;
		tck = 1'b0;
		tms = 1'b1;
		tdi = 1'b0;
		uart_rx = 1'b1; // idle line
		err_count = 0;
		err_at_start = 0;
		test_count = 0;
		failed_count = 0;
		repeat (2) @(posedge clk_osc);
		#1;
		rst = 1'b0;
		repeat (RESET_STRETCH + 2) @(posedge clk_osc); // rst_sys tail

		// idcode is the dr after test-logic-reset
		jtag_reset();
		scan_dr(32'h0, 32, dout);
		check_value("tdo", dout, IDCODE);
		finish_test("idcode after reset");

		scan_ir(IR_BYPASS);
		din = $urandom();
		scan_dr(din, 32, dout);
		check_value("tdo", dout, {din[30:0], 1'b0}); // one bit late, captured 0 first
		finish_test("bypass delay");

		scan_ir(IR_UART_DR);
		for (int n = 0; n < N_BYTES; n++) begin
			b = uart_byte_t'($urandom());
			wait_tx_free();
			fork
				scan_dr(32'({2'b01, b}), UART_DR_W, dout); // write bit 8
				capture_frame(frame, frame_ok, FRAME_WAIT);
			join
			if (!frame_ok)
				report_error("no start bit on uart_tx after a write");
			else
				check_value("uart_tx", 32'(frame), 32'(frame_bits(b)));
		end
		finish_test("uart tx write");

		scan_ir(IR_UART_DR);
		for (int n = 0; n < N_BYTES; n++) begin
			b = uart_byte_t'($urandom());
			send_uart_byte(b);
			idle_clocks(6); // tck edges carry the byte over
			scan_dr(32'h0, UART_DR_W, dout);
			check_value("uart_dr", 32'(dout[9:0]), 32'(capture_word(1'b0, 1'b1, b)));
			scan_dr(32'h0, UART_DR_W, dout); // flag cleared by the first read
			check_value("uart_dr", 32'(dout[9:0]), 32'(capture_word(1'b0, 1'b0, b)));
		end
		finish_test("uart rx read");

		for (int i = 0; i < 8; i++) begin
			idle_clocks(1);
			@(negedge clk_osc);
			check_value("led", 32'(led), 32'(LED_ACTIVE));
		end
		// tck now parked high
		waited = 0;
		do begin
			@(negedge clk_osc);
			waited++;
		end while (led === LED_ACTIVE && waited < LED_HOLD + 4);
		if (led === LED_ACTIVE)
			report_error("led still active long after tck stopped");
		finish_test("activity led");

		$display("%0d tests, %0d failed, %0d errors", test_count, failed_count, err_count);
		if (err_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- list.f
+incdir+tests
hdl/board_pkg.sv
hdl/cdc_word.sv
hdl/fpga_reset.sv
hdl/reset_sync.sv
hdl/jtag_tap.sv
hdl/jtag_uart_bridge.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/activity_led.sv
hdl/fpga_icebreaker.sv
tests/tb_fpga_icebreaker.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps
TOP   = tb_fpga_icebreaker
FLIST = list.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
